/* dram_pkg.sv */
`default_nettype none

package dram_pkg;

    // timing counter and refresh counter width
    localparam int TIME_W = 10;

    // device timings in clock cycles
    localparam logic [TIME_W-1:0] tRCD   = 10'd3;
    localparam logic [TIME_W-1:0] tRP    = 10'd3;
    localparam logic [TIME_W-1:0] tRL    = 10'd4;
    localparam logic [TIME_W-1:0] tWL    = 10'd3;
    localparam logic [TIME_W-1:0] tBURST = 10'd4;
    localparam logic [TIME_W-1:0] tRFC   = 10'd8;
    localparam logic [TIME_W-1:0] tREFI  = 10'd200;

    // bus and address widths
    localparam int DQ_W   = 16;
    localparam int BANK_W = 2;
    localparam int ROW_W  = 12;
    localparam int COL_W  = 8;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    // index of a word inside one burst
    localparam int BEAT_W     = $clog2(tBURST);

    typedef enum logic [3:0] {
        IDLE, ACTIVATE, ACTIVATING, READ, READING, WRITE, WRITING,
        PRECHARGE, PRECHARGING, REFRESH, REFRESHING
    } cmd_state_t;

    typedef enum logic [2:0] {NOP, ACT, RD, WR, PRE, REF} dram_cmd_e;

    // word 0 is the first beat on the bus
    typedef logic [tBURST-1:0][DQ_W-1:0] line_t;

    typedef struct packed {
        logic              write;
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
        line_t             wdata;
    } dram_req_t;

    typedef struct packed {
        dram_cmd_e         cmd;
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
    } dram_bus_t;

    typedef struct packed {
        logic tACT_done;
        logic tRD_done;
        logic tWR_done;
        logic tPRE_done;
        logic tREF_done;
        logic rf_req;
        logic rd_en;
        logic wr_en;
        logic clear;
    } timing_t;

endpackage

`default_nettype wire

/* flex_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module flex_counter (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        enable,
    input  logic [dram_pkg::TIME_W-1:0] count_load,
    output logic [dram_pkg::TIME_W-1:0] count,
    output logic                        count_done
);
    import dram_pkg::*;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end
        else if (enable) begin
            count <= count_load;
        end
        else if (count > TIME_W'(1)) begin
            // stops at one so the done flag holds until the next load
            count <= count - 1'b1;
        end
    end

    // the window of length count_load ends on the cycle the count is one
    assign count_done = (count == TIME_W'(1));

endmodule

`default_nettype wire

/* sync_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    import dram_pkg::*;

    payload_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  push;
    logic                  pop;

    assign in_ready  = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (push) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave the occupancy unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end
            else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

/* timing_signal.sv */
`timescale 1ns/1ns
`default_nettype none

module timing_signal (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dram_pkg::cmd_state_t cmd_state,
    output dram_pkg::timing_t    timing
);
    import dram_pkg::*;

    logic [TIME_W-1:0] time_load;
    logic [TIME_W-1:0] time_count;
    logic              time_counter_en;
    logic              time_count_done;

    logic [TIME_W-1:0] refresh_count;
    logic [TIME_W-1:0] next_refresh_count;
    logic [TIME_W-1:0] refresh_limit;
    logic [TIME_W-1:0] next_refresh_limit;
    logic              rf_req;

    always_comb begin
        timing          = '0;
        timing.rf_req   = rf_req;
        time_counter_en = 1'b0;
        time_load       = '0;

        case (cmd_state)
            ACTIVATE: begin
                time_counter_en = 1'b1;
                time_load       = tRCD;
            end
            ACTIVATING: begin
                timing.tACT_done = time_count_done;
            end
            READ: begin
                time_counter_en = 1'b1;
                time_load       = tRL + tBURST;
            end
            READING: begin
                // data beats occupy the last tBURST counts of the window
                timing.rd_en    = (time_count <= tBURST);
                timing.tRD_done = time_count_done;
                timing.clear    = time_count_done;
            end
            WRITE: begin
                time_counter_en = 1'b1;
                time_load       = tWL + tBURST;
            end
            WRITING: begin
                timing.wr_en    = (time_count <= tBURST);
                timing.tWR_done = time_count_done;
            end
            PRECHARGE: begin
                time_counter_en = 1'b1;
                time_load       = tRP;
            end
            PRECHARGING: begin
                timing.tPRE_done = time_count_done;
            end
            REFRESH: begin
                time_counter_en = 1'b1;
                time_load       = tRFC;
            end
            REFRESHING: begin
                timing.tREF_done = time_count_done;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            refresh_count <= '0;
            refresh_limit <= tREFI;
        end
        else begin
            refresh_count <= next_refresh_count;
            refresh_limit <= next_refresh_limit;
        end
    end

    always_comb begin
        next_refresh_count = refresh_count + 1'b1;
        if (cmd_state == REFRESH || cmd_state == REFRESHING) begin
            next_refresh_count = '0;
        end

        // a late refresh shortens the next interval by the overrun
        next_refresh_limit = refresh_limit;
        if (cmd_state == REFRESH) begin
            if (refresh_count > tREFI) begin
                next_refresh_limit = tREFI - (refresh_count - tREFI);
            end
            else begin
                next_refresh_limit = tREFI;
            end
        end

        rf_req = (refresh_count >= refresh_limit) && (cmd_state != REFRESH);
    end

    flex_counter i_time_counter (
        .CLK        (CLK),
        .nRST       (nRST),
        .enable     (time_counter_en),
        .count_load (time_load),
        .count      (time_count),
        .count_done (time_count_done)
    );

endmodule

`default_nettype wire

/* command_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module command_fsm (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 head_valid,
    output logic                 head_ready,
    input  dram_pkg::dram_req_t  head,
    input  logic                 rsp_full,
    input  dram_pkg::timing_t    timing,
    output dram_pkg::cmd_state_t cmd_state,
    output dram_pkg::dram_bus_t  bus,
    output dram_pkg::line_t      cur_wdata
);
    import dram_pkg::*;

    cmd_state_t next_state;
    dram_req_t  cur_req;
    logic       start_access;

    // a read is held back while its line would have nowhere to go
    assign start_access = head_valid && (head.write || !rsp_full);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cmd_state <= IDLE;
        end
        else begin
            cmd_state <= next_state;
        end
    end

    always_comb begin
        next_state = cmd_state;
        case (cmd_state)
            IDLE: begin
                // refresh wins over a waiting request
                if (timing.rf_req) begin
                    next_state = REFRESH;
                end
                else if (start_access) begin
                    next_state = ACTIVATE;
                end
            end
            ACTIVATE:    next_state = ACTIVATING;
            ACTIVATING:  if (timing.tACT_done) next_state = cur_req.write ? WRITE : READ;
            READ:        next_state = READING;
            READING:     if (timing.tRD_done) next_state = PRECHARGE;
            WRITE:       next_state = WRITING;
            WRITING:     if (timing.tWR_done) next_state = PRECHARGE;
            PRECHARGE:   next_state = PRECHARGING;
            PRECHARGING: if (timing.tPRE_done) next_state = IDLE;
            REFRESH:     next_state = REFRESHING;
            REFRESHING:  if (timing.tREF_done) next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    // capture the head as the access starts, pop it during ACT
    always_ff @(posedge CLK) begin
        if (cmd_state == IDLE && next_state == ACTIVATE) begin
            cur_req <= head;
        end
    end

    assign head_ready = (cmd_state == ACTIVATE);
    assign cur_wdata  = cur_req.wdata;

    always_comb begin
        bus.bank = cur_req.bank;
        bus.row  = cur_req.row;
        bus.col  = cur_req.col;
        case (cmd_state)
            ACTIVATE:  bus.cmd = ACT;
            READ:      bus.cmd = RD;
            WRITE:     bus.cmd = WR;
            PRECHARGE: bus.cmd = PRE;
            REFRESH:   bus.cmd = REF;
            default:   bus.cmd = NOP;
        endcase
    end

endmodule

`default_nettype wire

/* burst_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module burst_datapath (
    input  logic                      CLK,
    input  logic                      nRST,
    input  dram_pkg::timing_t         timing,
    input  dram_pkg::line_t           cur_wdata,
    output logic [dram_pkg::DQ_W-1:0] dq_out,
    output logic                      dq_oe,
    input  logic [dram_pkg::DQ_W-1:0] dq_in,
    output dram_pkg::line_t           rd_line,
    output logic                      rd_push
);
    import dram_pkg::*;

    logic [BEAT_W-1:0]             beat;
    logic [tBURST-2:0][DQ_W-1:0]   rd_shift;

    // beat index restarts at zero whenever no burst is running
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            beat <= '0;
        end
        else if (timing.wr_en || timing.rd_en) begin
            beat <= beat + 1'b1;
        end
        else begin
            beat <= '0;
        end
    end

    assign dq_oe  = timing.wr_en;
    assign dq_out = cur_wdata[beat];

    // new beats enter at the top so the first beat ends up in word 0
    always_ff @(posedge CLK) begin
        if (timing.rd_en) begin
            rd_shift <= {dq_in, rd_shift[tBURST-2:1]};
        end
    end

    // clear comes with the last beat, which is merged in directly
    assign rd_line = {dq_in, rd_shift};
    assign rd_push = timing.clear;

endmodule

`default_nettype wire

/* dram_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dram_ctrl_top (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  dram_pkg::dram_req_t       req,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output dram_pkg::line_t           rsp,
    output dram_pkg::dram_bus_t       bus,
    output logic [dram_pkg::DQ_W-1:0] dq_out,
    output logic                      dq_oe,
    input  logic [dram_pkg::DQ_W-1:0] dq_in
);
    import dram_pkg::*;

    logic       head_valid;
    logic       head_ready;
    dram_req_t  head;
    logic       rsp_in_ready;
    logic       rsp_full;
    cmd_state_t cmd_state;
    timing_t    timing;
    line_t      cur_wdata;
    line_t      rd_line;
    logic       rd_push;

    assign rsp_full = ~rsp_in_ready;

    sync_fifo #(.payload_t(dram_req_t)) i_req_fifo (
        .CLK(CLK), .nRST(nRST),
        .in_valid(req_valid), .in_ready(req_ready), .in_data(req),
        .out_valid(head_valid), .out_ready(head_ready), .out_data(head)
    );

    command_fsm i_command_fsm (
        .CLK(CLK), .nRST(nRST),
        .head_valid(head_valid), .head_ready(head_ready), .head(head),
        .rsp_full(rsp_full), .timing(timing), .cmd_state(cmd_state),
        .bus(bus), .cur_wdata(cur_wdata)
    );

    timing_signal i_timing_signal (
        .CLK(CLK), .nRST(nRST), .cmd_state(cmd_state), .timing(timing)
    );

    burst_datapath i_burst_datapath (
        .CLK(CLK), .nRST(nRST), .timing(timing), .cur_wdata(cur_wdata),
        .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in),
        .rd_line(rd_line), .rd_push(rd_push)
    );

    sync_fifo #(.payload_t(line_t)) i_rsp_fifo (
        .CLK(CLK), .nRST(nRST),
        .in_valid(rd_push), .in_ready(rsp_in_ready), .in_data(rd_line),
        .out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp)
    );

endmodule

`default_nettype wire

/* tb_dram_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dram_ctrl;
    import dram_pkg::*;

    localparam int ADDR_W         = BANK_W + ROW_W + COL_W;
    // IDLE, ACT, tRCD, RD, tRL + tBURST, PRE, tRP
    localparam int ACCESS_CYCLES  = int'(tRCD + tRL + tBURST + tRP) + 4;
    localparam int N_PAIRS        = 16;
    localparam int N_MIXED        = 8;
    localparam int N_HELD         = 2 * FIFO_DEPTH + 2;
    localparam int N_IDLE_REFS    = 3;
    localparam int QUIET_CYCLES   = int'(tRFC) + 4;
    localparam int STALL_CYCLES   = 2 * ACCESS_CYCLES;
    localparam int TEST_CYCLES    = (2 * N_PAIRS + N_MIXED + N_HELD) * ACCESS_CYCLES
                                  + N_IDLE_REFS * (int'(tREFI + tRFC) + 1 + ACCESS_CYCLES)
                                  + STALL_CYCLES;
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    logic            CLK = 1'b0;
    logic            nRST;
    logic            req_valid;
    logic            req_ready;
    dram_req_t       req;
    logic            rsp_valid;
    logic            rsp_ready;
    line_t           rsp;
    dram_bus_t       bus;
    logic [DQ_W-1:0] dq_out;
    logic            dq_oe;
    logic [DQ_W-1:0] dq_in;

    int    seed;
    int    cyc;
    int    errors;
    int    checks;
    logic  rsp_hold;
    logic  sends_done;
    line_t exp_q [$];
    line_t shadow [logic [ADDR_W-1:0]];
    line_t dev_mem [logic [ADDR_W-1:0]];

    // device model and bus monitor state
    logic [ROW_W-1:0]  open_row [1 << BANK_W];
    logic              row_open [1 << BANK_W];
    logic              last_rd;
    logic [ADDR_W-1:0] rdwr_addr;
    int                act_cyc;
    int                rdwr_cyc;
    int                pre_cyc;
    int                ref_cyc;
    int                ref_base;
    int                max_ref_gap;
    int                rd_cmds;
    int                acc_cmds;
    int                ref_cmds;

    dram_ctrl_top i_dram_ctrl_top (.*);

    initial begin
        forever #50 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cyc = cyc + 1;
    end

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // every word of the untouched memory depends on the whole address
    function automatic line_t fill_line(input logic [ADDR_W-1:0] a);
        line_t l;
        for (int w = 0; w < tBURST; w++) begin
            l[w] = DQ_W'(a) ^ DQ_W'(a >> 10) ^ DQ_W'(w << 12);
        end
        return l;
    endfunction

    // reference: the line a read must return, from the shadow memory
    function automatic line_t expected_line(input logic [ADDR_W-1:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return fill_line(a);
    endfunction

    function automatic line_t device_line(input logic [ADDR_W-1:0] a);
        if (dev_mem.exists(a)) begin
            return dev_mem[a];
        end
        return fill_line(a);
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic random_request(input logic wr, output dram_req_t r);
        r.write = wr;
        r.bank  = BANK_W'($random(seed));
        r.row   = ROW_W'($random(seed));
        r.col   = COL_W'($random(seed));
        for (int w = 0; w < tBURST; w++) begin
            r.wdata[w] = DQ_W'($random(seed));
        end
    endtask

    // offer one request, then update the shadow memory once it is taken
    task automatic send_request(input dram_req_t r);
        logic [ADDR_W-1:0] a;
        a = {r.bank, r.row, r.col};
        @(negedge CLK);
        req       = r;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(negedge CLK);
        end
        @(posedge CLK);
        if (r.write) begin
            shadow[a] = r.wdata;
        end
        else begin
            exp_q.push_back(expected_line(a));
        end
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    // done when all reads returned and the bus has been silent a while
    task automatic wait_drained;
        int quiet;
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge CLK);
            if (exp_q.size() == 0 && bus.cmd == NOP) begin
                quiet++;
            end
            else begin
                quiet = 0;
            end
        end
    endtask

    task automatic check_quiet;
        check_value("bus.cmd before first request", bus.cmd, NOP);
        check_value("dq_oe before first request", dq_oe, 1'b0);
        check_value("rsp_valid before first request", rsp_valid, 1'b0);
    endtask

    task automatic report_test(input int n, input string name, input int err_start);
        $display("test %0d %s: finished with %0d errors", n, name, errors - err_start);
    endtask

    // random gaps in rsp_ready unless the responses are held
    always @(negedge CLK) begin
        if (rsp_hold) begin
            rsp_ready = 1'b0;
        end
        else begin
            rsp_ready = ($random(seed) % 4) != 0;
        end
    end

    always @(posedge CLK) begin
        if (nRST && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a response arrived at %0t ns with no read outstanding", $time);
            end
            else begin
                check_value("read line", rsp, exp_q.pop_front());
            end
        end
    end

    // device model, sampled and driven on the falling edge
    always @(negedge CLK) begin
        line_t l;
        int    beat;
        if (nRST) begin
            if (bus.cmd != NOP) begin
                check_value("command too soon after PRE", (cyc - pre_cyc) > int'(tRP), 1'b1);
                check_value("command inside tRFC", (cyc - ref_cyc) > int'(tRFC), 1'b1);
            end
            case (bus.cmd)
                ACT: begin
                    check_value("ACT to a bank with an open row", row_open[bus.bank], 1'b0);
                    row_open[bus.bank] = 1'b1;
                    open_row[bus.bank] = bus.row;
                    act_cyc = cyc;
                end
                RD, WR: begin
                    check_value("RD or WR without ACT to its row",
                                row_open[bus.bank] && open_row[bus.bank] == bus.row, 1'b1);
                    check_value("ACT to RD or WR gap", cyc - act_cyc, tRCD + 1);
                    last_rd   = (bus.cmd == RD);
                    rdwr_cyc  = cyc;
                    rdwr_addr = {bus.bank, bus.row, bus.col};
                    acc_cmds++;
                    if (last_rd) begin
                        rd_cmds++;
                    end
                end
                PRE: begin
                    check_value("RD or WR to PRE gap", cyc - rdwr_cyc,
                                last_rd ? tRL + tBURST + 1 : tWL + tBURST + 1);
                    row_open[bus.bank] = 1'b0;
                    pre_cyc = cyc;
                end
                REF: begin
                    for (int b = 0; b < (1 << BANK_W); b++) begin
                        check_value("REF with a row open", row_open[b], 1'b0);
                    end
                    check_value("refresh interval within limit",
                                (cyc - ref_base) <= int'(tREFI) + ACCESS_CYCLES, 1'b1);
                    if (cyc - ref_base > max_ref_gap) begin
                        max_ref_gap = cyc - ref_base;
                    end
                    // the refresh counter restarts from zero once REFRESHING ends
                    ref_base = cyc + int'(tRFC) + 1;
                    ref_cyc  = cyc;
                    ref_cmds++;
                end
                default: begin
                end
            endcase

            beat = cyc - rdwr_cyc - int'(tWL) - 1;
            check_value("dq_oe window", dq_oe, !last_rd && beat >= 0 && beat < int'(tBURST));
            if (dq_oe) begin
                l       = device_line(rdwr_addr);
                l[beat] = dq_out;
                dev_mem[rdwr_addr] = l;
            end

            beat = cyc - rdwr_cyc - int'(tRL) - 1;
            if (last_rd && beat >= 0 && beat < int'(tBURST)) begin
                l     = device_line(rdwr_addr);
                dq_in = l[beat];
            end
            else begin
                dq_in = '0;
            end
        end
    end

    initial begin
        dram_req_t r;
        int        err_start;
        int        acc_start;
        int        ref_start;
        int        rd_start;
        int        stall;

        seed        = 72;
        nRST        = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        rsp_ready   = 1'b0;
        dq_in       = '0;
        rsp_hold    = 1'b1;
        sends_done  = 1'b0;
        last_rd     = 1'b0;
        act_cyc     = -1000;
        rdwr_cyc    = -1000;
        pre_cyc     = -1000;
        ref_cyc     = -1000;
        max_ref_gap = 0;
        for (int b = 0; b < (1 << BANK_W); b++) begin
            row_open[b] = 1'b0;
        end

        // test 1: quiet outputs through reset and up to the first request
        err_start = errors;
        repeat (3) begin
            @(negedge CLK);
            check_quiet();
        end
        nRST     = 1'b1;
        ref_base = cyc;
        repeat (5) begin
            @(negedge CLK);
            check_quiet();
        end
        report_test(1, "reset state", err_start);

        // test 2: each write is read back from the same address
        err_start = errors;
        rsp_hold  = 1'b0;
        for (int i = 0; i < N_PAIRS; i++) begin
            random_request(1'b1, r);
            send_request(r);
            r.write = 1'b0;
            send_request(r);
        end
        wait_drained();
        report_test(2, "write then read pairs", err_start);

        // test 3: mixed accesses, command order checked by the bus monitor
        err_start = errors;
        acc_start = acc_cmds;
        for (int i = 0; i < N_MIXED; i++) begin
            random_request($random(seed) & 1, r);
            send_request(r);
        end
        wait_drained();
        check_value("accesses seen on the bus", acc_cmds - acc_start, N_MIXED);
        report_test(3, "command sequence", err_start);

        // test 4: refreshes keep coming with nothing else to do
        err_start = errors;
        ref_start = ref_cmds;
        while (ref_cmds < ref_start + N_IDLE_REFS) begin
            @(negedge CLK);
        end
        report_test(4, $sformatf("idle refresh, longest gap %0d cycles", max_ref_gap),
                    err_start);

        // test 5: responses held back until the request side stalls
        err_start = errors;
        rd_start  = rd_cmds;
        rsp_hold  = 1'b1;
        fork
            begin
                for (int i = 0; i < N_HELD; i++) begin
                    random_request(1'b0, r);
                    send_request(r);
                end
                sends_done = 1'b1;
            end
            begin
                stall = 0;
                while (stall < STALL_CYCLES && !sends_done) begin
                    @(negedge CLK);
                    if (req_valid && !req_ready) begin
                        stall++;
                    end
                    else begin
                        stall = 0;
                    end
                end
                if (stall < STALL_CYCLES) begin
                    errors++;
                    $display("req_ready never fell while the responses were held");
                end
                check_value("reads issued while held", rd_cmds - rd_start <= FIFO_DEPTH, 1'b1);
                rsp_hold = 1'b0;
            end
        join
        wait_drained();
        report_test(5, "response back-pressure", err_start);

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end
        else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
dram_pkg.sv
flex_counter.sv
sync_fifo.sv
timing_signal.sv
command_fsm.sv
burst_datapath.sv
dram_ctrl_top.sv
tb_dram_ctrl.sv

/* Bender.yml */
package:
  name: dram_ctrl

sources:
  - files:
      - dram_pkg.sv
      - flex_counter.sv
      - sync_fifo.sv
      - timing_signal.sv
      - command_fsm.sv
      - burst_datapath.sv
      - dram_ctrl_top.sv
  - target: simulation
    files:
      - tb_dram_ctrl.sv
